// ==== Bender.yml ====
package:
  name: exec_stage

sources:
  - design/rv_exec_pkg.sv
  - design/exec_decode.sv
  - design/int_alu.sv
  - design/branch_unit.sv
  - design/exec_writeback.sv
  - design/exec_stage.sv
  - target: test
    files:
      - dv/exec_stage_tb.sv

// ==== design/branch_unit.sv ====
`default_nettype none

module branch_unit (
    input  rv_exec_pkg::br_cond_e          i_cond,
    input  logic                           i_is_jalr,
    input  logic [rv_exec_pkg::XLEN-1:0]   i_rs1_value,
    input  logic [rv_exec_pkg::XLEN-1:0]   i_rs2_value,
    input  logic [31:0]                    i_pc,
    input  logic [11:0]                    i_imm12,
    input  logic [19:0]                    i_uimm,
    output logic                           o_taken,
    output logic [rv_exec_pkg::XLEN-1:0]   o_target,
    output logic [rv_exec_pkg::XLEN-1:0]   o_link_value
);

    logic [rv_exec_pkg::XLEN-1:0] pc64;
    logic [rv_exec_pkg::XLEN-1:0] jalr_sum;

    assign pc64         = {32'h0, i_pc};
    assign o_link_value = pc64 + 64'd4; // also the fall-through pc.
    assign jalr_sum     = i_rs1_value + {{52{i_imm12[11]}}, i_imm12};

    always_comb begin
        case (i_cond)
            rv_exec_pkg::BR_EQ:     o_taken = (i_rs1_value == i_rs2_value);
            rv_exec_pkg::BR_NE:     o_taken = (i_rs1_value != i_rs2_value);
            rv_exec_pkg::BR_LT:     o_taken = ($signed(i_rs1_value) < $signed(i_rs2_value));
            rv_exec_pkg::BR_GE:     o_taken = ($signed(i_rs1_value) >= $signed(i_rs2_value));
            rv_exec_pkg::BR_LTU:    o_taken = (i_rs1_value < i_rs2_value);
            rv_exec_pkg::BR_GEU:    o_taken = (i_rs1_value >= i_rs2_value);
            rv_exec_pkg::BR_ALWAYS: o_taken = 1'b1;
            default:                o_taken = 1'b0;
        endcase
    end

    always_comb begin
        if (i_is_jalr) begin
            o_target = {jalr_sum[63:1], 1'b0};
        end else if (i_cond == rv_exec_pkg::BR_ALWAYS) begin
            o_target = pc64 + {{43{i_uimm[19]}}, i_uimm, 1'b0}; // jal.
        end else begin
            o_target = pc64 + {{51{i_imm12[11]}}, i_imm12, 1'b0};
        end
    end

    always_comb begin
        assert final (!i_is_jalr || !o_target[0])
            else $error("jalr target is odd");
    end

endmodule

`default_nettype wire

// ==== design/exec_decode.sv ====
`default_nettype none

module exec_decode (
    input  logic                  i_valid,
    input  logic [9:0]            i_opcode,
    input  logic [6:0]            i_funct7,
    output rv_exec_pkg::alu_op_e  o_alu_op,
    output logic                  o_alu_b_is_imm,
    output logic                  o_alu_a_is_pc,
    output logic                  o_alu_upper_imm,
    output logic                  o_alu_word,
    output rv_exec_pkg::br_cond_e o_br_cond,
    output rv_exec_pkg::res_src_e o_res_src,
    output logic                  o_illegal
);

    logic bad;

    always_comb begin
        o_alu_op        = rv_exec_pkg::ALU_ADD;
        o_alu_b_is_imm  = 1'b0;
        o_alu_a_is_pc   = 1'b0;
        o_alu_upper_imm = 1'b0;
        o_alu_word      = 1'b0;
        o_br_cond       = rv_exec_pkg::BR_NONE;
        o_res_src       = rv_exec_pkg::RES_ALU;
        bad             = 1'b0;
        casez (i_opcode)
            rv_exec_pkg::OPC_ADDI:  o_alu_b_is_imm = 1'b1;
            rv_exec_pkg::OPC_SLTI: begin
                o_alu_b_is_imm = 1'b1;
                o_alu_op       = rv_exec_pkg::ALU_SLT;
            end
            rv_exec_pkg::OPC_SLTIU: begin
                o_alu_b_is_imm = 1'b1;
                o_alu_op       = rv_exec_pkg::ALU_SLTU;
            end
            rv_exec_pkg::OPC_XORI: begin
                o_alu_b_is_imm = 1'b1;
                o_alu_op       = rv_exec_pkg::ALU_XOR;
            end
            rv_exec_pkg::OPC_ORI: begin
                o_alu_b_is_imm = 1'b1;
                o_alu_op       = rv_exec_pkg::ALU_OR;
            end
            rv_exec_pkg::OPC_ANDI: begin
                o_alu_b_is_imm = 1'b1;
                o_alu_op       = rv_exec_pkg::ALU_AND;
            end
            rv_exec_pkg::OPC_SLLI: begin
                o_alu_b_is_imm = 1'b1;
                o_alu_op       = rv_exec_pkg::ALU_SLL;
                bad            = (i_funct7[6:1] != 6'b000000); // bit 25 is shamt[5].
            end
            rv_exec_pkg::OPC_SRLI_SRAI: begin
                o_alu_b_is_imm = 1'b1;
                case (i_funct7[6:1])
                    6'b000000: o_alu_op = rv_exec_pkg::ALU_SRL;
                    6'b010000: o_alu_op = rv_exec_pkg::ALU_SRA;
                    default:   bad = 1'b1;
                endcase
            end
            rv_exec_pkg::OPC_ADDIW: begin
                o_alu_b_is_imm = 1'b1;
                o_alu_word     = 1'b1;
            end
            rv_exec_pkg::OPC_SLLIW: begin
                o_alu_b_is_imm = 1'b1;
                o_alu_word     = 1'b1;
                o_alu_op       = rv_exec_pkg::ALU_SLL;
                bad            = (i_funct7 != 7'b0000000);
            end
            rv_exec_pkg::OPC_SRLIW_SRAIW,
            rv_exec_pkg::OPC_SRLW_SRAW,
            rv_exec_pkg::OPC_SRL_SRA: begin
                o_alu_b_is_imm = ~i_opcode[5];
                o_alu_word     = i_opcode[3];
                case (i_funct7)
                    7'b0000000: o_alu_op = rv_exec_pkg::ALU_SRL;
                    7'b0100000: o_alu_op = rv_exec_pkg::ALU_SRA;
                    default:    bad = 1'b1;
                endcase
            end
            rv_exec_pkg::OPC_ADD_SUB,
            rv_exec_pkg::OPC_ADDW_SUBW: begin
                o_alu_word = i_opcode[3];
                case (i_funct7)
                    7'b0000000: o_alu_op = rv_exec_pkg::ALU_ADD;
                    7'b0100000: o_alu_op = rv_exec_pkg::ALU_SUB;
                    default:    bad = 1'b1;
                endcase
            end
            rv_exec_pkg::OPC_SLL,
            rv_exec_pkg::OPC_SLLW: begin
                o_alu_word = i_opcode[3];
                o_alu_op   = rv_exec_pkg::ALU_SLL;
                bad        = (i_funct7 != 7'b0000000);
            end
            rv_exec_pkg::OPC_SLT,
            rv_exec_pkg::OPC_SLTU,
            rv_exec_pkg::OPC_XOR,
            rv_exec_pkg::OPC_OR,
            rv_exec_pkg::OPC_AND: begin
                case (i_opcode[9:7])
                    3'b010:  o_alu_op = rv_exec_pkg::ALU_SLT;
                    3'b011:  o_alu_op = rv_exec_pkg::ALU_SLTU;
                    3'b100:  o_alu_op = rv_exec_pkg::ALU_XOR;
                    3'b110:  o_alu_op = rv_exec_pkg::ALU_OR;
                    default: o_alu_op = rv_exec_pkg::ALU_AND;
                endcase
                bad = (i_funct7 != 7'b0000000);
            end
            {3'b???, rv_exec_pkg::OPC_LUI}: begin
                o_alu_b_is_imm  = 1'b1;
                o_alu_upper_imm = 1'b1;
                o_alu_op        = rv_exec_pkg::ALU_PASS_B;
            end
            {3'b???, rv_exec_pkg::OPC_AUIPC}: begin
                o_alu_b_is_imm  = 1'b1;
                o_alu_upper_imm = 1'b1;
                o_alu_a_is_pc   = 1'b1;
            end
            {3'b???, rv_exec_pkg::OPC_JAL},
            rv_exec_pkg::OPC_JALR: begin
                o_br_cond = rv_exec_pkg::BR_ALWAYS;
                o_res_src = rv_exec_pkg::RES_LINK;
            end
            rv_exec_pkg::OPC_BEQ, rv_exec_pkg::OPC_BNE,
            rv_exec_pkg::OPC_BLT, rv_exec_pkg::OPC_BGE,
            rv_exec_pkg::OPC_BLTU, rv_exec_pkg::OPC_BGEU: begin
                o_br_cond = rv_exec_pkg::br_cond_e'(i_opcode[9:7] - 3'd2 * i_opcode[9]);
                o_res_src = rv_exec_pkg::RES_NONE; // next pc comes from the branch path.
            end
            rv_exec_pkg::OPC_LB, rv_exec_pkg::OPC_LH, rv_exec_pkg::OPC_LW,
            rv_exec_pkg::OPC_LD, rv_exec_pkg::OPC_LBU, rv_exec_pkg::OPC_LHU,
            rv_exec_pkg::OPC_LWU, rv_exec_pkg::OPC_SB, rv_exec_pkg::OPC_SH,
            rv_exec_pkg::OPC_SW, rv_exec_pkg::OPC_SD: begin
                o_alu_b_is_imm = 1'b1;
                o_res_src      = rv_exec_pkg::RES_AGEN;
            end
            default: bad = 1'b1;
        endcase
        if (bad) begin
            o_res_src = rv_exec_pkg::RES_NONE;
            o_br_cond = rv_exec_pkg::BR_NONE;
        end
        o_illegal = i_valid & bad;
    end

    always_comb begin
        assert final (!o_illegal || o_res_src == rv_exec_pkg::RES_NONE)
            else $error("illegal key selects a result");
        assert final (!i_valid || !$isunknown({o_alu_op, o_br_cond, o_res_src}))
            else $error("decode enums unknown");
    end

endmodule

`default_nettype wire

// ==== design/exec_stage.sv ====
`default_nettype none

module exec_stage (
    input  logic        clk,
    input  logic        i_arst_n,
    input  logic        i_valid,
    input  logic [9:0]  i_opcode,
    input  logic [11:0] i_imm12,
    input  logic [4:0]  i_rd,
    input  logic [19:0] i_uimm,
    input  logic [31:0] i_pc,
    input  logic [63:0] i_rs1_value,
    input  logic [63:0] i_rs2_value,
    output logic [63:0] o_result,
    output logic [4:0]  o_rd,
    output logic        o_wr_en,
    output logic        o_redirect,
    output logic [63:0] o_target_pc,
    output logic        o_agen_valid,
    output logic        o_illegal
);

    rv_exec_pkg::alu_op_e         alu_op;
    rv_exec_pkg::br_cond_e        br_cond;
    rv_exec_pkg::res_src_e        res_src;
    logic                         alu_b_is_imm;
    logic                         alu_a_is_pc;
    logic                         alu_upper_imm;
    logic                         alu_word;
    logic                         illegal;
    logic                         is_jalr;
    logic                         is_branch;
    logic                         br_taken;
    logic [rv_exec_pkg::XLEN-1:0] alu_a;
    logic [rv_exec_pkg::XLEN-1:0] alu_b;
    logic [rv_exec_pkg::XLEN-1:0] alu_result;
    logic [rv_exec_pkg::XLEN-1:0] br_target;
    logic [rv_exec_pkg::XLEN-1:0] link_value;

    assign alu_a = alu_a_is_pc ? {32'h0, i_pc} : i_rs1_value;
    assign alu_b = !alu_b_is_imm ? i_rs2_value :
                   alu_upper_imm ? {{32{i_uimm[19]}}, i_uimm, 12'h000} :
                                   {{52{i_imm12[11]}}, i_imm12};

    assign is_jalr   = (i_opcode == rv_exec_pkg::OPC_JALR);
    assign is_branch = (br_cond != rv_exec_pkg::BR_NONE) && (br_cond != rv_exec_pkg::BR_ALWAYS);

    exec_decode decode_i (
        .i_valid         (i_valid),
        .i_opcode        (i_opcode),
        .i_funct7        (i_imm12[11:5]),
        .o_alu_op        (alu_op),
        .o_alu_b_is_imm  (alu_b_is_imm),
        .o_alu_a_is_pc   (alu_a_is_pc),
        .o_alu_upper_imm (alu_upper_imm),
        .o_alu_word      (alu_word),
        .o_br_cond       (br_cond),
        .o_res_src       (res_src),
        .o_illegal       (illegal)
    );

    int_alu alu_i (
        .i_op     (alu_op),
        .i_word   (alu_word),
        .i_a      (alu_a),
        .i_b      (alu_b),
        .o_result (alu_result)
    );

    branch_unit branch_i (
        .i_cond       (br_cond),
        .i_is_jalr    (is_jalr),
        .i_rs1_value  (i_rs1_value),
        .i_rs2_value  (i_rs2_value),
        .i_pc         (i_pc),
        .i_imm12      (i_imm12),
        .i_uimm       (i_uimm),
        .o_taken      (br_taken),
        .o_target     (br_target),
        .o_link_value (link_value)
    );

    exec_writeback writeback_i (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_valid      (i_valid),
        .i_illegal    (illegal),
        .i_res_src    (res_src),
        .i_rd         (i_rd),
        .i_alu_result (alu_result),
        .i_link_value (link_value),
        .i_target     (br_target),
        .i_taken      (br_taken),
        .i_is_branch  (is_branch),
        .o_result     (o_result),
        .o_rd         (o_rd),
        .o_wr_en      (o_wr_en),
        .o_redirect   (o_redirect),
        .o_agen_valid (o_agen_valid),
        .o_illegal    (o_illegal),
        .o_target_pc  (o_target_pc)
    );

endmodule

`default_nettype wire

// ==== design/exec_writeback.sv ====
`default_nettype none

module exec_writeback (
    input  logic                           clk,
    input  logic                           i_arst_n,
    input  logic                           i_valid,
    input  logic                           i_illegal,
    input  rv_exec_pkg::res_src_e          i_res_src,
    input  logic [4:0]                     i_rd,
    input  logic [rv_exec_pkg::XLEN-1:0]   i_alu_result,
    input  logic [rv_exec_pkg::XLEN-1:0]   i_link_value,
    input  logic [rv_exec_pkg::XLEN-1:0]   i_target,
    input  logic                           i_taken,
    input  logic                           i_is_branch,
    output logic [rv_exec_pkg::XLEN-1:0]   o_result,
    output logic [4:0]                     o_rd,
    output logic                           o_wr_en,
    output logic                           o_redirect,
    output logic                           o_agen_valid,
    output logic                           o_illegal,
    output logic [rv_exec_pkg::XLEN-1:0]   o_target_pc
);

    logic [rv_exec_pkg::XLEN-1:0] result_d;
    logic                         writes;

    always_comb begin
        if (i_is_branch) begin
            result_d = i_taken ? i_target : i_link_value; // next pc.
        end else begin
            case (i_res_src)
                rv_exec_pkg::RES_LINK: result_d = i_link_value;
                rv_exec_pkg::RES_NONE: result_d = '0;
                default:               result_d = i_alu_result; // alu or address.
            endcase
        end
    end

    assign writes = (i_res_src == rv_exec_pkg::RES_ALU) || (i_res_src == rv_exec_pkg::RES_LINK);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_result     <= '0;
            o_rd         <= '0;
            o_wr_en      <= 1'b0;
            o_redirect   <= 1'b0;
            o_agen_valid <= 1'b0;
            o_illegal    <= 1'b0;
            o_target_pc  <= '0;
        end else begin
            o_result     <= result_d;
            o_rd         <= i_rd;
            o_wr_en      <= i_valid & ~i_illegal & writes & (i_rd != 5'd0);
            o_redirect   <= i_valid & i_taken;
            o_agen_valid <= i_valid & ~i_illegal & (i_res_src == rv_exec_pkg::RES_AGEN);
            o_illegal    <= i_valid & i_illegal;
            o_target_pc  <= i_target;
        end
    end

    assert property (@(posedge clk) disable iff (!i_arst_n)
        $onehot0({o_wr_en, o_agen_valid, o_illegal}))
        else $error("write, agen and illegal overlap");

endmodule

`default_nettype wire

// ==== design/int_alu.sv ====
`default_nettype none

module int_alu (
    input  rv_exec_pkg::alu_op_e           i_op,
    input  logic                           i_word,
    input  logic [rv_exec_pkg::XLEN-1:0]   i_a,
    input  logic [rv_exec_pkg::XLEN-1:0]   i_b,
    output logic [rv_exec_pkg::XLEN-1:0]   o_result
);

    logic [5:0]                   shamt;
    logic [rv_exec_pkg::XLEN-1:0] a_srl;
    logic [rv_exec_pkg::XLEN-1:0] a_sra;
    logic [rv_exec_pkg::XLEN-1:0] raw;

    // word shifts see only the low half of a, extended to suit the shift.
    assign shamt = i_word ? {1'b0, i_b[4:0]} : i_b[5:0];
    assign a_srl = i_word ? {32'h0, i_a[31:0]} : i_a;
    assign a_sra = i_word ? {{32{i_a[31]}}, i_a[31:0]} : i_a;

    always_comb begin
        case (i_op)
            rv_exec_pkg::ALU_ADD:    raw = i_a + i_b;
            rv_exec_pkg::ALU_SUB:    raw = i_a - i_b;
            rv_exec_pkg::ALU_SLL:    raw = i_a << shamt;
            rv_exec_pkg::ALU_SLT:    raw = {63'h0, $signed(i_a) < $signed(i_b)};
            rv_exec_pkg::ALU_SLTU:   raw = {63'h0, i_a < i_b};
            rv_exec_pkg::ALU_XOR:    raw = i_a ^ i_b;
            rv_exec_pkg::ALU_SRL:    raw = a_srl >> shamt;
            rv_exec_pkg::ALU_SRA:    raw = $unsigned($signed(a_sra) >>> shamt);
            rv_exec_pkg::ALU_OR:     raw = i_a | i_b;
            rv_exec_pkg::ALU_AND:    raw = i_a & i_b;
            default:                 raw = i_b; // pass b for lui.
        endcase
    end

    assign o_result = i_word ? {{32{raw[31]}}, raw[31:0]} : raw;

    always_comb begin
        assert final (!i_word || o_result[63:32] == {32{o_result[31]}})
            else $error("word result not sign extended");
    end

endmodule

`default_nettype wire

// ==== design/rv_exec_pkg.sv ====
`default_nettype none

package rv_exec_pkg;

    localparam int XLEN = 64;

    // key is {funct3, opcode}.
    localparam logic [9:0] OPC_ADDI        = 10'h013;
    localparam logic [9:0] OPC_SLTI        = 10'h113;
    localparam logic [9:0] OPC_SLTIU       = 10'h193;
    localparam logic [9:0] OPC_XORI        = 10'h213;
    localparam logic [9:0] OPC_ORI         = 10'h313;
    localparam logic [9:0] OPC_ANDI        = 10'h393;
    localparam logic [9:0] OPC_SLLI        = 10'h093;
    localparam logic [9:0] OPC_SRLI_SRAI   = 10'h293;
    localparam logic [9:0] OPC_ADDIW       = 10'h01b;
    localparam logic [9:0] OPC_SLLIW       = 10'h09b;
    localparam logic [9:0] OPC_SRLIW_SRAIW = 10'h29b;

    localparam logic [9:0] OPC_ADD_SUB     = 10'h033;
    localparam logic [9:0] OPC_SLL         = 10'h0b3;
    localparam logic [9:0] OPC_SLT         = 10'h133;
    localparam logic [9:0] OPC_SLTU        = 10'h1b3;
    localparam logic [9:0] OPC_XOR         = 10'h233;
    localparam logic [9:0] OPC_SRL_SRA     = 10'h2b3;
    localparam logic [9:0] OPC_OR          = 10'h333;
    localparam logic [9:0] OPC_AND         = 10'h3b3;
    localparam logic [9:0] OPC_ADDW_SUBW   = 10'h03b;
    localparam logic [9:0] OPC_SLLW        = 10'h0bb;
    localparam logic [9:0] OPC_SRLW_SRAW   = 10'h2bb;

    // funct3 is not part of these keys.
    localparam logic [6:0] OPC_LUI         = 7'h37;
    localparam logic [6:0] OPC_AUIPC       = 7'h17;
    localparam logic [6:0] OPC_JAL         = 7'h6f;
    localparam logic [9:0] OPC_JALR        = 10'h067;

    localparam logic [9:0] OPC_BEQ         = 10'h063;
    localparam logic [9:0] OPC_BNE         = 10'h0e3;
    localparam logic [9:0] OPC_BLT         = 10'h263;
    localparam logic [9:0] OPC_BGE         = 10'h2e3;
    localparam logic [9:0] OPC_BLTU        = 10'h363;
    localparam logic [9:0] OPC_BGEU        = 10'h3e3;

    localparam logic [9:0] OPC_LB          = 10'h003;
    localparam logic [9:0] OPC_LH          = 10'h083;
    localparam logic [9:0] OPC_LW          = 10'h103;
    localparam logic [9:0] OPC_LD          = 10'h183;
    localparam logic [9:0] OPC_LBU         = 10'h203;
    localparam logic [9:0] OPC_LHU         = 10'h283;
    localparam logic [9:0] OPC_LWU         = 10'h303;
    localparam logic [9:0] OPC_SB          = 10'h023;
    localparam logic [9:0] OPC_SH          = 10'h0a3;
    localparam logic [9:0] OPC_SW          = 10'h123;
    localparam logic [9:0] OPC_SD          = 10'h1a3;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_ALWAYS, BR_NONE
    } br_cond_e;

    typedef enum logic [1:0] {
        RES_ALU, RES_LINK, RES_AGEN, RES_NONE
    } res_src_e;

endpackage

`default_nettype wire

// ==== dv/exec_stage_tb.sv ====
`default_nettype none

module exec_stage_tb;

    localparam int CLK_PERIOD = 8;
    localparam int FIELDS     = 14; // words per stimulus line.
    localparam int MAX_VECS   = 64;

    logic        clk;
    logic        i_arst_n;
    logic        i_valid;
    logic [9:0]  i_opcode;
    logic [11:0] i_imm12;
    logic [4:0]  i_rd;
    logic [19:0] i_uimm;
    logic [31:0] i_pc;
    logic [63:0] i_rs1_value;
    logic [63:0] i_rs2_value;
    logic [63:0] o_result;
    logic [4:0]  o_rd;
    logic        o_wr_en;
    logic        o_redirect;
    logic [63:0] o_target_pc;
    logic        o_agen_valid;
    logic        o_illegal;

    logic [63:0] stim_mem [0:FIELDS*MAX_VECS-1];
    int          vec_count;
    logic        loaded = 1'b0;

    exec_stage exec_stage_i (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_valid      (i_valid),
        .i_opcode     (i_opcode),
        .i_imm12      (i_imm12),
        .i_rd         (i_rd),
        .i_uimm       (i_uimm),
        .i_pc         (i_pc),
        .i_rs1_value  (i_rs1_value),
        .i_rs2_value  (i_rs2_value),
        .o_result     (o_result),
        .o_rd         (o_rd),
        .o_wr_en      (o_wr_en),
        .o_redirect   (o_redirect),
        .o_target_pc  (o_target_pc),
        .o_agen_valid (o_agen_valid),
        .o_illegal    (o_illegal)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] next_lfsr(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    task automatic compare_field(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        assert (actual === expected)
        else begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic check_reset_outputs();
        compare_field("o_result", 64'h0, o_result);
        compare_field("o_rd", 64'h0, o_rd);
        compare_field("o_wr_en", 64'h0, o_wr_en);
        compare_field("o_redirect", 64'h0, o_redirect);
        compare_field("o_target_pc", 64'h0, o_target_pc);
        compare_field("o_agen_valid", 64'h0, o_agen_valid);
        compare_field("o_illegal", 64'h0, o_illegal);
    endtask

    task automatic drive_vector(input int idx);
        int base;
        base = idx * FIELDS;
        i_valid     <= 1'b1;
        i_opcode    <= stim_mem[base][9:0];
        i_imm12     <= stim_mem[base + 1][11:0];
        i_rd        <= stim_mem[base + 2][4:0];
        i_uimm      <= stim_mem[base + 3][19:0];
        i_pc        <= stim_mem[base + 4][31:0];
        i_rs1_value <= stim_mem[base + 5];
        i_rs2_value <= stim_mem[base + 6];
    endtask

    // idx below zero means the slot was idle.
    task automatic check_slot(input int idx);
        int base;
        base = idx * FIELDS;
        if (idx < 0) begin
            compare_field("o_wr_en", 64'h0, o_wr_en);
            compare_field("o_redirect", 64'h0, o_redirect);
            compare_field("o_agen_valid", 64'h0, o_agen_valid);
            compare_field("o_illegal", 64'h0, o_illegal);
        end else begin
            if (!stim_mem[base + 13][0]) begin
                compare_field("o_result", stim_mem[base + 7], o_result);
            end
            compare_field("o_rd", stim_mem[base + 8], o_rd);
            compare_field("o_wr_en", stim_mem[base + 9], o_wr_en);
            compare_field("o_redirect", stim_mem[base + 10], o_redirect);
            if (stim_mem[base + 10][0]) begin
                compare_field("o_target_pc", stim_mem[base + 11], o_target_pc); // only on redirect.
            end
            compare_field("o_agen_valid", stim_mem[base + 12], o_agen_valid);
            compare_field("o_illegal", stim_mem[base + 13], o_illegal);
        end
    endtask

    initial begin
        logic [31:0] lfsr;
        int          vec;
        int          cur_idx;
        int          prev_idx;
        logic        just_idled;

        i_arst_n    = 1'b0;
        i_valid     = 1'b0;
        i_opcode    = '0;
        i_imm12     = '0;
        i_rd        = '0;
        i_uimm      = '0;
        i_pc        = '0;
        i_rs1_value = '0;
        i_rs2_value = '0;
        lfsr        = 32'h9b83a6c8;

        for (int i = 0; i < FIELDS * MAX_VECS; i++) begin
            stim_mem[i] = '1; // marks words past the end of the file.
        end
        $readmemh("dv/exec_stim.txt", stim_mem);
        vec_count = 0;
        while (vec_count < MAX_VECS && stim_mem[vec_count * FIELDS] !== '1) begin
            vec_count++;
        end
        if (vec_count == 0) begin
            $display("no stimulus lines were read from dv/exec_stim.txt");
            $display("RESULT: FAIL");
            $fatal(1, "empty stimulus");
        end
        loaded = 1'b1;

        repeat (3) begin
            @(posedge clk);
            @(negedge clk);
            check_reset_outputs();
        end
        @(posedge clk);
        i_arst_n <= 1'b1;
        @(negedge clk);
        check_reset_outputs();

        vec        = 0;
        prev_idx   = -1;
        just_idled = 1'b0;
        while (vec < vec_count) begin
            if (!just_idled) begin
                lfsr = next_lfsr(lfsr);
            end
            @(posedge clk);
            if (!just_idled && lfsr[0]) begin
                i_valid    <= 1'b0; // bubble.
                cur_idx    = -1;
                just_idled = 1'b1;
            end else begin
                drive_vector(vec);
                cur_idx    = vec;
                vec++;
                just_idled = 1'b0;
            end
            @(negedge clk);
            check_slot(prev_idx);
            prev_idx = cur_idx;
        end

        @(posedge clk);
        i_valid <= 1'b0;
        @(negedge clk);
        check_slot(prev_idx);
        @(posedge clk);
        @(negedge clk);
        check_slot(-1);

        $display("RESULT: PASS");
        $finish;
    end

    initial begin
        wait (loaded === 1'b1);
        #((2 * vec_count + 10) * CLK_PERIOD);
        $display("watchdog expired before the stimulus finished");
        $display("RESULT: FAIL");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// ==== dv/exec_stim.txt ====
// opcode imm12 rd uimm pc rs1 rs2, then expected result rd wr_en redirect target agen illegal
// target is compared only on a redirect, result is not compared for illegal keys
013 005 01 0 1000 10 0 15 01 1 0 0 0 0 // addi
033 000 03 0 1000 7 9 10 03 1 0 0 0 0 // add
033 400 04 0 1000 5 7 fffffffffffffffe 04 1 0 0 0 0 // sub
133 000 05 0 1000 ffffffffffffffff 1 1 05 1 0 0 0 0 // slt
1b3 000 06 0 1000 ffffffffffffffff 1 0 06 1 0 0 0 0 // sltu
113 fff 07 0 1000 fffffffffffffffe 0 1 07 1 0 0 0 0 // slti
193 fff 08 0 1000 5 0 1 08 1 0 0 0 0 // sltiu
233 000 09 0 1000 ff00 ff0 f0f0 09 1 0 0 0 0 // xor
393 0f0 0a 0 1000 ff 0 f0 0a 1 0 0 0 0 // andi
093 03f 0b 0 1000 1 0 8000000000000000 0b 1 0 0 0 0 // slli
293 004 0c 0 1000 8000000000000000 0 0800000000000000 0c 1 0 0 0 0 // srli
293 404 0d 0 1000 8000000000000000 0 f800000000000000 0d 1 0 0 0 0 // srai
2b3 400 0e 0 1000 8000000000000000 44 f800000000000000 0e 1 0 0 0 0 // sra
0b3 000 0f 0 1000 3 41 6 0f 1 0 0 0 0 // sll
03b 000 10 0 1000 7fffffff 1 ffffffff80000000 10 1 0 0 0 0 // addw
03b 400 11 0 1000 100000005 3 2 11 1 0 0 0 0 // subw
0bb 000 12 0 1000 1 3f ffffffff80000000 12 1 0 0 0 0 // sllw
2bb 000 13 0 1000 ffffffff80000000 4 8000000 13 1 0 0 0 0 // srlw
2bb 400 14 0 1000 80000000 4 fffffffff8000000 14 1 0 0 0 0 // sraw
09b 001 15 0 1000 40000000 0 ffffffff80000000 15 1 0 0 0 0 // slliw
29b 401 16 0 1000 80000000 0 ffffffffc0000000 16 1 0 0 0 0 // sraiw
01b 001 17 0 1000 ffffffff 0 0 17 1 0 0 0 0 // addiw
037 000 18 12345 1000 0 0 12345000 18 1 0 0 0 0 // lui
017 000 19 1 1000 0 0 2000 19 1 0 0 0 0 // auipc
063 008 00 0 1000 5 5 1010 00 0 1 1010 0 0 // beq taken
0e3 008 00 0 1000 5 5 1004 00 0 0 0 0 0 // bne not taken
263 ffc 00 0 1000 ffffffffffffffff 1 ff8 00 0 1 ff8 0 0 // blt taken backward
2e3 010 00 0 1000 1 ffffffffffffffff 1020 00 0 1 1020 0 0 // bge taken
3e3 004 00 0 1000 ffffffffffffffff 1 1008 00 0 1 1008 0 0 // bgeu taken
06f 000 01 100 1000 0 0 1004 01 1 1 1200 0 0 // jal
067 007 02 0 1000 3000 0 1004 02 1 1 3006 0 0 // jalr odd sum
067 fff 00 0 1000 2000 0 1004 00 0 1 1ffe 0 0 // jalr to x0
183 010 05 0 1000 2000 0 2010 05 0 0 0 1 0 // ld
1a3 ff8 00 0 1000 2000 0 1ff8 00 0 0 0 1 0 // sd
013 001 00 0 1000 1 0 2 00 0 0 0 0 0 // addi to x0
073 000 03 0 1000 0 0 0 03 0 0 0 0 1 // unknown key
033 020 04 0 1000 5 7 0 04 0 0 0 0 1 // add with bad funct7
2bb 420 05 0 1000 5 7 0 05 0 0 0 0 1 // sraw with bad funct7

// ==== exec_stage.f ====
design/rv_exec_pkg.sv
design/exec_decode.sv
design/int_alu.sv
design/branch_unit.sv
design/exec_writeback.sv
design/exec_stage.sv
dv/exec_stage_tb.sv
